// ==== hw/ptp_ts_pkg.sv ====
// timestamp format: field widths, one-second rollover value, PPS stretch bit, time types
package ptp_ts_pkg;

    // full 96-bit timestamp
    localparam int TS_W = 96;

    // seconds field
    localparam int TS_S_W = 48;

    // nanoseconds field
    localparam int TS_NS_W = 30;

    // fractional nanoseconds below the ns field
    localparam int FNS_W = 16;

    // ns field wraps here and carries into seconds
    localparam logic [TS_NS_W-1:0] NS_PER_S = 30'd1_000_000_000;

    // ns bit that ends the stretched PPS, roughly 0.54 s into the second
    localparam int PPS_STR_BIT = 29;

    // nanoseconds with fraction, as kept by the accumulator
    typedef logic [TS_NS_W+FNS_W-1:0] ts_ns_t;

    // seconds count
    typedef logic [TS_S_W-1:0] ts_s_t;

endpackage

// ==== hw/ptp_apb_pkg.sv ====
// APB bus widths and register offset map of the clock
package ptp_apb_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // byte offsets, one 32-bit word each
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_PERIOD_FNS = 8'h00,
        REG_PERIOD_NS  = 8'h04,
        REG_LOAD_S_LO  = 8'h08,
        REG_LOAD_S_HI  = 8'h0C,
        // writing this one commits the load
        REG_LOAD_NS    = 8'h10
    } reg_addr_e;

endpackage

// ==== hw/ptp_ctrl_if.sv ====
// interface ptp_ctrl_if: period and timestamp load commands into the counter
interface ptp_ctrl_if;

    // increment per clock, ns with fraction
    ptp_ts_pkg::ts_ns_t period;

    // step target, fraction always zero
    ptp_ts_pkg::ts_s_t  load_s;
    ptp_ts_pkg::ts_ns_t load_ns;

    // single-cycle strobe
    logic               load;

    modport regs (
        output period,
        output load_s,
        output load_ns,
        output load
    );

    modport counter (
        input period,
        input load_s,
        input load_ns,
        input load
    );

endinterface

// ==== hw/ptp_time_if.sv ====
// interface ptp_time_if: live time of day with rollover and step flags
interface ptp_time_if;

    ptp_ts_pkg::ts_s_t  ts_s;
    ptp_ts_pkg::ts_ns_t ts_ns;

    // second boundary crossed this cycle
    logic               rollover;

    // time was loaded this cycle
    logic               step;

    modport counter (
        output ts_s,
        output ts_ns,
        output rollover,
        output step
    );

    modport out (
        input ts_s,
        input ts_ns,
        input rollover,
        input step
    );

endinterface

// ==== hw/ptp_apb_regs.sv ====
// module ptp_apb_regs: APB slave with period and timestamp load registers
module ptp_apb_regs (
    input  logic                                output_clk,
    input  logic                                output_rst,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [ptp_apb_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic [ptp_apb_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [ptp_apb_pkg::APB_DATA_W-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr,
    ptp_ctrl_if.regs                            ctrl
);

    logic [ptp_ts_pkg::FNS_W-1:0]       period_fns_reg;
    logic [ptp_ts_pkg::TS_NS_W-1:0]     period_ns_reg;
    logic [31:0]                        load_s_lo_reg;
    logic [ptp_ts_pkg::TS_S_W-33:0]     load_s_hi_reg;
    logic [ptp_ts_pkg::TS_NS_W-1:0]     load_ns_reg;
    logic                               load_reg;
    logic                               setup;
    logic                               access;
    logic                               addr_ok;
    logic [ptp_apb_pkg::APB_DATA_W-1:0] rd_data;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // no wait states
    assign pready = access;

    // address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (paddr)
            ptp_apb_pkg::REG_PERIOD_FNS: rd_data[ptp_ts_pkg::FNS_W-1:0] = period_fns_reg;
            ptp_apb_pkg::REG_PERIOD_NS:  rd_data[ptp_ts_pkg::TS_NS_W-1:0] = period_ns_reg;
            ptp_apb_pkg::REG_LOAD_S_LO:  rd_data = load_s_lo_reg;
            ptp_apb_pkg::REG_LOAD_S_HI:  rd_data[ptp_ts_pkg::TS_S_W-33:0] = load_s_hi_reg;
            ptp_apb_pkg::REG_LOAD_NS:    rd_data[ptp_ts_pkg::TS_NS_W-1:0] = load_ns_reg;
            default:                     addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge output_clk) begin
        if (output_rst) begin
            period_fns_reg <= '0;
            period_ns_reg  <= '0;
            load_s_lo_reg  <= '0;
            load_s_hi_reg  <= '0;
            load_ns_reg    <= '0;
            load_reg       <= 1'b0;
            prdata         <= '0;
            pslverr        <= 1'b0;
        end else begin
            load_reg <= 1'b0;
            // decoded in setup so both are valid through the access phase
            pslverr  <= setup && !addr_ok;
            if (setup && !pwrite) begin
                prdata <= rd_data;
            end
            if (access && pwrite) begin
                case (paddr)
                    ptp_apb_pkg::REG_PERIOD_FNS: begin
                        period_fns_reg <= pwdata[ptp_ts_pkg::FNS_W-1:0];
                    end
                    ptp_apb_pkg::REG_PERIOD_NS: begin
                        period_ns_reg <= pwdata[ptp_ts_pkg::TS_NS_W-1:0];
                    end
                    ptp_apb_pkg::REG_LOAD_S_LO: begin
                        load_s_lo_reg <= pwdata;
                    end
                    ptp_apb_pkg::REG_LOAD_S_HI: begin
                        load_s_hi_reg <= pwdata[ptp_ts_pkg::TS_S_W-33:0];
                    end
                    ptp_apb_pkg::REG_LOAD_NS: begin
                        load_ns_reg <= pwdata[ptp_ts_pkg::TS_NS_W-1:0];
                        load_reg    <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign ctrl.period  = {period_ns_reg, period_fns_reg};
    assign ctrl.load_s  = {load_s_hi_reg, load_s_lo_reg};
    assign ctrl.load_ns = {load_ns_reg, {ptp_ts_pkg::FNS_W{1'b0}}};
    assign ctrl.load    = load_reg;

endmodule

// ==== hw/ptp_tod_counter.sv ====
// ns/s accumulator ptp_tod_counter with one-second rollover and step load
module ptp_tod_counter (
    input  logic        output_clk,
    input  logic        output_rst,
    ptp_ctrl_if.counter ctrl,
    ptp_time_if.counter tod
);

    ptp_ts_pkg::ts_s_t                                  ts_s_reg;
    ptp_ts_pkg::ts_ns_t                                 ts_ns_reg;
    logic                                               rollover_reg;
    logic                                               step_reg;
    // one extra bit so the sum cannot overflow
    logic [ptp_ts_pkg::TS_NS_W+ptp_ts_pkg::FNS_W:0]     ns_sum;
    logic [ptp_ts_pkg::TS_NS_W+ptp_ts_pkg::FNS_W:0]     ns_wrap;
    logic                                               wrap;

    always_comb begin
        ns_sum  = {1'b0, ts_ns_reg} + {1'b0, ctrl.period};
        ns_wrap = ns_sum - {1'b0, ptp_ts_pkg::NS_PER_S, {ptp_ts_pkg::FNS_W{1'b0}}};
        // direct compare against one second
        wrap    = ns_sum >= {1'b0, ptp_ts_pkg::NS_PER_S, {ptp_ts_pkg::FNS_W{1'b0}}};
    end

    always_ff @(posedge output_clk) begin
        if (output_rst) begin
            ts_s_reg     <= '0;
            ts_ns_reg    <= '0;
            rollover_reg <= 1'b0;
            step_reg     <= 1'b0;
        end else if (ctrl.load) begin
            // step wins over the normal update
            ts_s_reg     <= ctrl.load_s;
            ts_ns_reg    <= ctrl.load_ns;
            rollover_reg <= 1'b0;
            step_reg     <= 1'b1;
        end else begin
            rollover_reg <= wrap;
            step_reg     <= 1'b0;
            if (wrap) begin
                ts_s_reg  <= ts_s_reg + 1'b1;
                ts_ns_reg <= ns_wrap[ptp_ts_pkg::TS_NS_W+ptp_ts_pkg::FNS_W-1:0];
            end else begin
                ts_ns_reg <= ns_sum[ptp_ts_pkg::TS_NS_W+ptp_ts_pkg::FNS_W-1:0];
            end
        end
    end

    assign tod.ts_s     = ts_s_reg;
    assign tod.ts_ns    = ts_ns_reg;
    assign tod.rollover = rollover_reg;
    assign tod.step     = step_reg;

endmodule

// ==== hw/ptp_ts_output.sv ====
// module ptp_ts_output: 96-bit timestamp packing, step flag, PPS and stretched PPS
module ptp_ts_output (
    input  logic                          output_clk,
    input  logic                          output_rst,
    ptp_time_if.out                       tod,
    output logic [ptp_ts_pkg::TS_W-1:0]   output_ts,
    output logic                          output_ts_step,
    output logic                          output_pps,
    output logic                          output_pps_str
);

    always_ff @(posedge output_clk) begin
        if (output_rst) begin
            output_ts      <= '0;
            output_ts_step <= 1'b0;
            output_pps     <= 1'b0;
            output_pps_str <= 1'b0;
        end else begin
            // seconds, two pad bits, ns and fraction
            output_ts <= {
                tod.ts_s,
                {(ptp_ts_pkg::TS_W - ptp_ts_pkg::TS_S_W - ptp_ts_pkg::TS_NS_W
                    - ptp_ts_pkg::FNS_W){1'b0}},
                tod.ts_ns
            };
            output_ts_step <= tod.step;
            output_pps     <= tod.rollover;

            // stretched pulse, set at the second, cleared partway through
            if (tod.rollover) begin
                output_pps_str <= 1'b1;
            end else if (tod.ts_ns[ptp_ts_pkg::PPS_STR_BIT+ptp_ts_pkg::FNS_W]) begin
                output_pps_str <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/ptp_clock_top.sv ====
// module ptp_clock_top: APB-programmed PTP clock, register stage, counter and output stage
module ptp_clock_top (
    input  logic                                output_clk,
    input  logic                                output_rst,

    // APB slave
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [ptp_apb_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic [ptp_apb_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [ptp_apb_pkg::APB_DATA_W-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr,

    // time of day and PPS
    output logic [ptp_ts_pkg::TS_W-1:0]         output_ts,
    output logic                                output_ts_step,
    output logic                                output_pps,
    output logic                                output_pps_str
);

    ptp_ctrl_if ctrl_if ();
    ptp_time_if time_if ();

    ptp_apb_regs u_regs (
        .output_clk (output_clk),
        .output_rst (output_rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ctrl       (ctrl_if)
    );

    ptp_tod_counter u_counter (
        .output_clk (output_clk),
        .output_rst (output_rst),
        .ctrl       (ctrl_if),
        .tod        (time_if)
    );

    ptp_ts_output u_output (
        .output_clk     (output_clk),
        .output_rst     (output_rst),
        .tod            (time_if),
        .output_ts      (output_ts),
        .output_ts_step (output_ts_step),
        .output_pps     (output_pps),
        .output_pps_str (output_pps_str)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
// module tb_clk_gen: 100 ns testbench clock and synchronous reset
module tb_clk_gen (
    output logic output_clk,
    output logic output_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        output_clk = 1'b0;
        forever #50 output_clk = ~output_clk;
    end

    // held for four rising edges
    initial begin
        output_rst = 1'b1;
        repeat (4) @(posedge output_clk);
        #10 output_rst = 1'b0;
    end

endmodule

// ==== bench/ptp_clock_chk.sv ====
// module ptp_clock_chk: APB and PPS assertions, bound into ptp_clock_top
module ptp_clock_chk (
    input logic                        output_clk,
    input logic                        output_rst,
    input logic                        psel,
    input logic                        penable,
    input logic                        pready,
    input logic                        pslverr,
    input logic [ptp_ts_pkg::TS_W-1:0] output_ts,
    input logic                        output_pps,
    input logic                        output_pps_str
);
    timeunit 1ns;
    timeprecision 100ps;

    a_pready: assert property (@(posedge output_clk) disable iff (output_rst)
        (psel && penable) |-> pready)
        else $error("pready low in an APB access phase");

    a_pps_str: assert property (@(posedge output_clk) disable iff (output_rst)
        output_pps |-> output_pps_str)
        else $error("output_pps high without output_pps_str");

    // ns field sits above the fraction
    a_ns_range: assert property (@(posedge output_clk) disable iff (output_rst)
        output_ts[ptp_ts_pkg::FNS_W +: ptp_ts_pkg::TS_NS_W] < ptp_ts_pkg::NS_PER_S)
        else $error("output_ts nanoseconds not below one second");

    a_slverr: assert property (@(posedge output_clk) disable iff (output_rst)
        !(psel && penable) |-> !pslverr)
        else $error("pslverr high outside an APB access phase");

endmodule

bind ptp_clock_top ptp_clock_chk u_chk (.*);

// ==== bench/ptp_clock_tb.sv ====
// testbench ptp_clock_tb with APB tasks, LFSR, row table of loads and periods, checks, watchdog
module ptp_clock_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [47:0] load_s;
        logic [29:0] load_ns;
        logic [29:0] per_ns;
        logic [15:0] per_fns;
        int          cycles;
        bit          rand_s;
        logic [47:0] exp_s;
        logic [45:0] exp_ns;
        int          exp_pps;
    } row_t;

    logic        output_clk;
    logic        output_rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [95:0] output_ts;
    logic        output_ts_step;
    logic        output_pps;
    logic        output_pps_str;
    row_t        rows [4];
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    bit          table_ready;

    tb_clk_gen u_clk (.output_clk(output_clk), .output_rst(output_rst));

    ptp_clock_top u_dut (.*);

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [47:0] rand_bits(input int n);
        logic [47:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[46:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // expected time after the row's cycles by the one-second rollover rule
    function automatic row_t predict(input row_t r);
        logic [46:0] ns;
        logic [46:0] one_sec;
        ns = {1'b0, r.load_ns, 16'h0};
        one_sec = {1'b0, ptp_ts_pkg::NS_PER_S, 16'h0};
        r.exp_s = r.load_s;
        r.exp_pps = 0;
        repeat (r.cycles) begin
            ns = ns + {1'b0, r.per_ns, r.per_fns};
            if (ns >= one_sec) begin
                ns = ns - one_sec;
                r.exp_s = r.exp_s + 1;
                r.exp_pps++;
            end
        end
        r.exp_ns = ns[45:0];
        return r;
    endfunction

    task automatic build_table();
        rows[0] = '{48'd5, 30'd1000, 30'd8, 16'h8000, 20, 1'b0, '0, '0, 0};
        rows[1] = '{48'h1234_5678_9ABC, 30'd999_950_000, 30'd100_000_000, 16'h0, 8, 1'b0,
                    '0, '0, 0};
        rows[2] = '{48'd0, 30'd999_999_990, 30'd3, 16'h4000, 12, 1'b1, '0, '0, 0};
        rows[3] = '{48'd0, 30'h2000_0000, 30'd6, 16'h4000, 16, 1'b1, '0, '0, 0};
        foreach (rows[i]) begin
            if (rows[i].rand_s) begin
                rows[i].load_s = rand_bits(48);
            end
            rows[i] = predict(rows[i]);
        end
    endtask

    task automatic compare(input string name, input logic [95:0] exp, input logic [95:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "mismatch");
    endtask

    // starts and ends 10 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel = 1'b1;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge output_clk);
        #10 penable = 1'b1;
        @(negedge output_clk);
        compare("pready", 96'd1, 96'(pready));
        rdata = prdata;
        err = pslverr;
        @(posedge output_clk);
        #10 psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        compare($sformatf("pslverr@%h", addr), '0, 96'(err));
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        compare($sformatf("pslverr@%h", addr), '0, 96'(err));
        compare($sformatf("prdata@%h", addr), 96'(exp), 96'(rd));
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [46:0] m_ns;
        logic [46:0] one_sec;
        logic        m_wrap;
        logic        str_exp;
        bit          str_known;
        int          pps_seen;
        int          err0;
        r = rows[idx];
        err0 = errors;
        one_sec = {1'b0, ptp_ts_pkg::NS_PER_S, 16'h0};
        m_ns = {1'b0, r.load_ns, 16'h0};
        str_exp = 1'b0;
        // a load past the stretch bit clears the stretched pulse
        str_known = m_ns[ptp_ts_pkg::PPS_STR_BIT + ptp_ts_pkg::FNS_W];
        pps_seen = 0;
        apb_write(ptp_apb_pkg::REG_PERIOD_FNS, {16'h0, r.per_fns});
        apb_write(ptp_apb_pkg::REG_PERIOD_NS, {2'b0, r.per_ns});
        apb_write(ptp_apb_pkg::REG_LOAD_S_LO, r.load_s[31:0]);
        apb_write(ptp_apb_pkg::REG_LOAD_S_HI, {16'h0, r.load_s[47:32]});
        apb_write(ptp_apb_pkg::REG_LOAD_NS, {2'b0, r.load_ns});
        @(posedge output_clk);
        #10;
        compare("output_ts_step", '0, 96'(output_ts_step));
        // loaded value reaches the output two edges after the access edge
        @(posedge output_clk);
        #10;
        compare("output_ts", {r.load_s, 2'b0, r.load_ns, 16'h0}, output_ts);
        compare("output_ts_step", 96'd1, 96'(output_ts_step));
        compare("output_pps", '0, 96'(output_pps));
        repeat (r.cycles) begin
            @(posedge output_clk);
            #10;
            m_ns = m_ns + {1'b0, r.per_ns, r.per_fns};
            m_wrap = m_ns >= one_sec;
            if (m_wrap) begin
                m_ns = m_ns - one_sec;
                str_exp = 1'b1;
                str_known = 1'b1;
            end else if (m_ns[ptp_ts_pkg::PPS_STR_BIT + ptp_ts_pkg::FNS_W]) begin
                str_exp = 1'b0;
                str_known = 1'b1;
            end
            pps_seen += int'(output_pps);
            compare("output_pps", 96'(m_wrap), 96'(output_pps));
            compare("output_ts_step", '0, 96'(output_ts_step));
            if (str_known) begin
                compare("output_pps_str", 96'(str_exp), 96'(output_pps_str));
            end
        end
        compare("output_ts seconds", 96'(r.exp_s), 96'(output_ts[95:48]));
        compare("output_ts ns", 96'(r.exp_ns), 96'(output_ts[45:0]));
        compare("pps count", 96'(r.exp_pps), 96'(pps_seen));
        report_test($sformatf("row %0d load %0d.%0d", idx, r.load_s, r.load_ns), err0);
    endtask

    initial begin
        logic [7:0]  reg_addr [5];
        logic [31:0] reg_wr [5];
        logic [31:0] reg_rd [5];
        logic [31:0] rd;
        logic        err;
        int          err0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        lfsr = 16'd74;
        build_table();
        table_ready = 1'b1;
        reg_addr = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10};
        reg_wr = '{32'hDEAD_A5C3, 32'hC000_0007, 32'h89AB_CDEF, 32'hFFFF_0123, 32'hC123_4567};
        reg_rd = '{32'h0000_A5C3, 32'h0000_0007, 32'h89AB_CDEF, 32'h0000_0123, 32'h0123_4567};
        wait (!output_rst);

        err0 = errors;
        compare("output_ts", '0, output_ts);
        compare("output_ts_step", '0, 96'(output_ts_step));
        compare("output_pps", '0, 96'(output_pps));
        compare("output_pps_str", '0, 96'(output_pps_str));
        compare("prdata", '0, 96'(prdata));
        compare("pslverr", '0, 96'(pslverr));
        foreach (reg_addr[i]) begin
            apb_read(reg_addr[i], 32'h0);
        end
        report_test("reset values", err0);

        // unused upper bits are dropped on write
        err0 = errors;
        foreach (reg_addr[i]) begin
            apb_write(reg_addr[i], reg_wr[i]);
        end
        foreach (reg_addr[i]) begin
            apb_read(reg_addr[i], reg_rd[i]);
        end
        apb_xfer(1'b1, 8'h14, 32'hFFFF_FFFF, rd, err);
        compare("pslverr@14", 96'd1, 96'(err));
        foreach (reg_addr[i]) begin
            apb_read(reg_addr[i], reg_rd[i]);
        end
        report_test("register access", err0);

        foreach (rows[i]) begin
            run_row(i);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        longint limit;
        wait (table_ready);
        // reset, register tests and per-row APB traffic
        limit = 120;
        foreach (rows[i]) begin
            limit += rows[i].cycles;
        end
        #(2 * limit * 100);
        $display("timeout: the run did not finish within %0d ns", 2 * limit * 100);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== files.f ====
hw/ptp_ts_pkg.sv
hw/ptp_apb_pkg.sv
hw/ptp_ctrl_if.sv
hw/ptp_time_if.sv
hw/ptp_apb_regs.sv
hw/ptp_tod_counter.sv
hw/ptp_ts_output.sv
hw/ptp_clock_top.sv
bench/tb_clk_gen.sv
bench/ptp_clock_chk.sv
bench/ptp_clock_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the PTP clock testbench

VERILATOR ?= verilator
TOP       ?= ptp_clock_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
